// ==== tb_vi_core.sv ====
// Testbench for the integer core, driving instruction words from the case file
`timescale 1ns/100ps

module tb_vi_core;

	localparam int mult_stages = 5;
	localparam int max_cases = 64;
	localparam int reset_cycles = 10;
	localparam int cycles_per_case = 40;

	logic              clk_i;
	logic              arst_n_i;
	logic              instr_valid_i;
	vi_pkg::word_t     instr_i;
	logic              instr_ready_o;
	logic              wb_valid_o;
	vi_pkg::reg_addr_t wb_dest_o;
	vi_pkg::word_t     wb_data_o;

	vi_pkg::word_t     case_instr [max_cases];
	int                case_dest [max_cases];
	vi_pkg::word_t     case_value [max_cases];
	int                num_cases;
	logic              cases_loaded;

	// Expected register writes in program order
	int                exp_dest_q [$];
	vi_pkg::word_t     exp_value_q [$];

	int                value_errors;
	int                other_errors;

	vi_core #(
		.mult_stages	(mult_stages)
	) i_dut (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.instr_valid_i	(instr_valid_i),
		.instr_i	(instr_i),
		.instr_ready_o	(instr_ready_o),
		.wb_valid_o	(wb_valid_o),
		.wb_dest_o	(wb_dest_o),
		.wb_data_o	(wb_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic check_value(input string name, input vi_pkg::word_t got,
			input vi_pkg::word_t expected);
		if (got !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			value_errors++;
		end
	endtask

	task automatic load_cases();
		int            fd;
		int            fields;
		string         line;
		vi_pkg::word_t word;
		int            dest;
		vi_pkg::word_t value;
		num_cases = 0;
		fd = $fopen("vi_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file vi_cases.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			fields = $fgets(line, fd);
			if (line.len() == 0 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%h %d %h", word, dest, value);
			if (fields != 3)
				continue;
			if (num_cases >= max_cases) begin
				$display("Case file holds more than %0d cases, the rest is ignored", max_cases);
				other_errors++;
				break;
			end
			case_instr[num_cases] = word;
			case_dest[num_cases]  = dest;
			case_value[num_cases] = value;
			num_cases++;
		end
		$fclose(fd);
		if (num_cases == 0) begin
			$display("No cases were read from the case file");
			other_errors++;
		end
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic send_instruction(input vi_pkg::word_t word, input int dest,
			input vi_pkg::word_t value);
		logic taken;
		if (dest != 0) begin
			exp_dest_q.push_back(dest);
			exp_value_q.push_back(value);
		end
		instr_valid_i = 1'b1;
		instr_i       = word;
		taken         = 1'b0;
		while (!taken) begin
			@(posedge clk_i);
			taken = instr_ready_o;
		end
		@(negedge clk_i);
		instr_valid_i = 1'b0;
		instr_i       = '0;
	endtask

	// Oldest pending write to the same register must match
	task automatic take_write(input vi_pkg::reg_addr_t dest, input vi_pkg::word_t data);
		int idx;
		idx = -1;
		for (int i = 0; i < exp_dest_q.size(); i++) begin
			if (idx < 0 && exp_dest_q[i] == int'(dest))
				idx = i;
		end
		if (idx < 0) begin
			$display("Write to x%0d with data %h at %0t ns was not expected", dest, data, $time);
			other_errors++;
		end else begin
			check_value($sformatf("wb_data_o for x%0d", dest), data, exp_value_q[idx]);
			exp_dest_q.delete(idx);
			exp_value_q.delete(idx);
		end
	endtask

	always @(posedge clk_i) begin
		if (arst_n_i && wb_valid_o)
			take_write(wb_dest_o, wb_data_o);
	end

	initial begin
		int idle;
		idle          = $urandom(32'h808a);
		instr_valid_i = 1'b0;
		instr_i       = '0;
		arst_n_i      = 1'b0;
		value_errors  = 0;
		other_errors  = 0;
		cases_loaded  = 1'b0;
		load_cases();
		cases_loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk_i);
		@(negedge clk_i);
		// Empty core accepts at once and writes nothing
		check_value("instr_ready_o", instr_ready_o, 1'b1);
		check_value("wb_valid_o", wb_valid_o, 1'b0);
		arst_n_i = 1'b1;
		for (int n = 0; n < num_cases; n++) begin
			idle = $urandom_range(3, 0);
			repeat (idle) @(negedge clk_i);
			send_instruction(case_instr[n], case_dest[n], case_value[n]);
		end
		while (exp_dest_q.size() != 0)
			@(posedge clk_i);
		// Room for a stray write from the last multiplies
		repeat (mult_stages + 4) @(posedge clk_i);
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (cases_loaded === 1'b1);
		#((num_cases * cycles_per_case + reset_cycles) * 100);
		$display("Timeout: the run did not finish, %0d expected writes still pending",
			exp_dest_q.size());
		other_errors++;
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verilog.f ====
vi_pkg.sv
vi_issue_if.sv
vi_result_if.sv
vi_int_registers.sv
vi_mult_pipe.sv
vi_decode.sv
vi_execute.sv
vi_writeback.sv
vi_core.sv
tb_vi_core.sv

// ==== vi_cases.txt ====
# Columns: instruction word (hex), expected destination register (decimal, 0 = no write),
# expected written value (hex)
06400093 1 00000064
FFD08113 2 00000061
002081B3 3 000000C5
40310233 4 FFFFFF9C
123452B7 5 12345000
6782E293 5 12345678
0F02F313 6 00000070
FFF34393 7 FFFFFF8F
00609433 8 00640000
006254B3 9 0000FFFF
00122533 10 00000001
0072F5B3 11 12345608
00946633 12 0064FFFF
005646B3 13 1250A987
02208733 14 000025E4
027287B3 15 F6E5D508
02948833 16 FFFE0001
010708B3 17 FFFE25E5
02150933 18 00000064
00700913 18 00000007
00508013 0 00000000
0000A983 0 00000000
000909B3 19 00000007
02208033 0 00000000
00000A33 20 00000000

// ==== vi_core.sv ====
// Integer core top: decode, execute with multiply pipeline, and writeback
`timescale 1ns/100ps

module vi_core #(
	parameter int mult_stages = 5
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              instr_valid_i,
	input  vi_pkg::word_t     instr_i,
	output logic              instr_ready_o,
	output logic              wb_valid_o,
	output vi_pkg::reg_addr_t wb_dest_o,
	output vi_pkg::word_t     wb_data_o
);

	vi_issue_if  issue_bus ();
	vi_result_if result_bus ();

	// Writeback outputs also feed the register file and bypass in decode
	vi_decode #(
		.mult_stages	(mult_stages)
	) i_decode (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.instr_valid_i	(instr_valid_i),
		.instr_i	(instr_i),
		.instr_ready_o	(instr_ready_o),
		.wb_valid_i	(wb_valid_o),
		.wb_dest_i	(wb_dest_o),
		.wb_data_i	(wb_data_o),
		.issue		(issue_bus.source),
		.result		(result_bus.monitor)
	);

	vi_execute #(
		.mult_stages	(mult_stages)
	) i_execute (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.issue		(issue_bus.sink),
		.result		(result_bus.source)
	);

	vi_writeback i_writeback (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.result		(result_bus.sink),
		.wb_valid_o	(wb_valid_o),
		.wb_dest_o	(wb_dest_o),
		.wb_data_o	(wb_data_o)
	);

endmodule

// ==== vi_decode.sv ====
// Decode stage: instruction register, field decode, bypassed operands, multiply scoreboard
`timescale 1ns/100ps

module vi_decode #(
	parameter int mult_stages = 5
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              instr_valid_i,
	input  vi_pkg::word_t     instr_i,
	output logic              instr_ready_o,
	input  logic              wb_valid_i,
	input  vi_pkg::reg_addr_t wb_dest_i,
	input  vi_pkg::word_t     wb_data_i,
	vi_issue_if.source        issue,
	vi_result_if.monitor      result
);

	logic                   dec_valid;
	vi_pkg::word_t          dec_instr;
	vi_pkg::opcode_e        opcode;
	vi_pkg::reg_addr_t      rs1;
	vi_pkg::reg_addr_t      rs2;
	vi_pkg::reg_addr_t      rd;
	logic                   known;
	logic                   is_mult;
	logic                   write_en;
	logic                   use_rs1;
	logic                   use_rs2;
	vi_pkg::alu_op_e        alu_op;
	vi_pkg::word_t          imm;
	vi_pkg::word_t          rf_data_a;
	vi_pkg::word_t          rf_data_b;
	logic [mult_stages-1:0] sb_valid;
	vi_pkg::reg_addr_t      sb_dest [mult_stages];
	logic                   raw_hazard;
	logic                   waw_hazard;
	logic                   stall;
	logic                   issue_go;

	assign opcode   = vi_pkg::opcode_e'(dec_instr[6:0]);
	assign rd       = dec_instr[11:7];
	assign rs1      = dec_instr[19:15];
	assign rs2      = dec_instr[24:20];
	assign write_en = known && rd != '0;

	always_comb begin
		known   = 1'b0;
		is_mult = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		alu_op  = vi_pkg::alu_add;
		imm     = {{20{dec_instr[31]}}, dec_instr[31:20]};
		case (opcode)
		vi_pkg::op_reg: begin
			use_rs1 = 1'b1;
			use_rs2 = 1'b1;
			if (dec_instr[31:25] == 7'b0000001 && dec_instr[14:12] == 3'b000) begin
				known   = 1'b1;
				is_mult = 1'b1;
			end else if (dec_instr[31:25] == 7'b0100000 && dec_instr[14:12] == 3'b000) begin
				known  = 1'b1;
				alu_op = vi_pkg::alu_sub;
			end else if (dec_instr[31:25] == 7'b0000000) begin
				known = 1'b1;
				case (dec_instr[14:12])
				3'b000: alu_op = vi_pkg::alu_add;
				3'b001: alu_op = vi_pkg::alu_sll;
				3'b010: alu_op = vi_pkg::alu_slt;
				3'b100: alu_op = vi_pkg::alu_xor;
				3'b101: alu_op = vi_pkg::alu_srl;
				3'b110: alu_op = vi_pkg::alu_or;
				3'b111: alu_op = vi_pkg::alu_and;
				default: known = 1'b0;
				endcase
			end
		end
		vi_pkg::op_imm: begin
			use_rs1 = 1'b1;
			known   = 1'b1;
			case (dec_instr[14:12])
			3'b000: alu_op = vi_pkg::alu_add;
			3'b100: alu_op = vi_pkg::alu_xor;
			3'b110: alu_op = vi_pkg::alu_or;
			3'b111: alu_op = vi_pkg::alu_and;
			default: known = 1'b0;
			endcase
		end
		vi_pkg::op_lui: begin
			known  = 1'b1;
			alu_op = vi_pkg::alu_pass_b;
			imm    = {dec_instr[31:12], 12'b0};
		end
		default: ;
		endcase
	end

	vi_int_registers i_int_registers (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.rd_addr_a_i	(rs1),
		.rd_addr_b_i	(rs2),
		.wr_en_i	(wb_valid_i),
		.wr_addr_i	(wb_dest_i),
		.wr_data_i	(wb_data_i),
		.rd_data_a_o	(rf_data_a),
		.rd_data_b_o	(rf_data_b)
	);

	// Youngest value wins: execute, then last multiply stage, then writeback
	function automatic vi_pkg::word_t bypass(input vi_pkg::reg_addr_t addr,
			input vi_pkg::word_t rf_data);
		if (result.alu_valid && result.alu_dest == addr)
			return result.alu_data;
		if (result.mult_valid && result.mult_dest == addr)
			return result.mult_data;
		if (wb_valid_i && wb_dest_i == addr)
			return wb_data_i;
		return rf_data;
	endfunction

	// sb entry 0 mirrors the execute register, entry k multiply stage k
	always_comb begin
		raw_hazard = 1'b0;
		waw_hazard = 1'b0;
		for (int k = 0; k < mult_stages; k++) begin
			if (sb_valid[k]) begin
				if ((use_rs1 && rs1 == sb_dest[k]) || (use_rs2 && rs2 == sb_dest[k]))
					raw_hazard = 1'b1;
				if (!is_mult && write_en && rd == sb_dest[k])
					waw_hazard = 1'b1;
			end
		end
		// A multiply about to enter its last stage owns the next writeback slot
		stall = dec_valid && (raw_hazard || waw_hazard ||
			(!is_mult && sb_valid[mult_stages-1]));
	end

	assign issue_go      = dec_valid && !stall;
	assign instr_ready_o = !dec_valid || issue_go;

	assign issue.valid     = issue_go;
	assign issue.alu_op    = alu_op;
	assign issue.is_mult   = is_mult;
	assign issue.dest      = rd;
	assign issue.write_en  = write_en;

	always_comb begin
		issue.operand_a = bypass(rs1, rf_data_a);
		issue.operand_b = use_rs2 ? bypass(rs2, rf_data_b) : imm;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dec_valid <= 1'b0;
			sb_valid  <= '0;
		end else begin
			if (instr_valid_i && instr_ready_o)
				dec_valid <= 1'b1;
			else if (issue_go)
				dec_valid <= 1'b0;
			sb_valid <= {sb_valid[mult_stages-2:0], issue_go && is_mult && write_en};
		end
	end

	always_ff @(posedge clk_i) begin
		if (instr_valid_i && instr_ready_o)
			dec_instr <= instr_i;
		sb_dest[0] <= rd;
		for (int k = 1; k < mult_stages; k++) begin
			sb_dest[k] <= sb_dest[k-1];
		end
	end

	// A non-multiply op never meets a multiply result in its execute cycle
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		issue.valid && !issue.is_mult |=> !result.mult_valid);

endmodule

// ==== vi_execute.sv ====
// Execute stage: operation register, integer ALU and the multiply pipeline
`timescale 1ns/100ps

module vi_execute #(
	parameter int mult_stages = 5
) (
	input  logic         clk_i,
	input  logic         arst_n_i,
	vi_issue_if.sink     issue,
	vi_result_if.source  result
);

	logic              ex_valid;
	vi_pkg::alu_op_e   ex_alu_op;
	logic              ex_is_mult;
	vi_pkg::reg_addr_t ex_dest;
	logic              ex_write_en;
	vi_pkg::word_t     ex_a;
	vi_pkg::word_t     ex_b;
	vi_pkg::word_t     alu_data;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			ex_valid <= 1'b0;
		else
			ex_valid <= issue.valid;
	end

	always_ff @(posedge clk_i) begin
		ex_alu_op   <= issue.alu_op;
		ex_is_mult  <= issue.is_mult;
		ex_dest     <= issue.dest;
		ex_write_en <= issue.write_en;
		ex_a        <= issue.operand_a;
		ex_b        <= issue.operand_b;
	end

	always_comb begin
		case (ex_alu_op)
		vi_pkg::alu_add:    alu_data = ex_a + ex_b;
		vi_pkg::alu_sub:    alu_data = ex_a - ex_b;
		vi_pkg::alu_and:    alu_data = ex_a & ex_b;
		vi_pkg::alu_or:     alu_data = ex_a | ex_b;
		vi_pkg::alu_xor:    alu_data = ex_a ^ ex_b;
		vi_pkg::alu_sll:    alu_data = ex_a << ex_b[4:0];
		vi_pkg::alu_srl:    alu_data = ex_a >> ex_b[4:0];
		vi_pkg::alu_slt:    alu_data = {{(vi_pkg::xlen-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
		vi_pkg::alu_pass_b: alu_data = ex_b;
		default:            alu_data = '0;
		endcase
	end

	assign result.alu_valid = ex_valid && !ex_is_mult && ex_write_en;
	assign result.alu_dest  = ex_dest;
	assign result.alu_data  = alu_data;

	// Multiplies to x0 never start
	vi_mult_pipe #(
		.mult_stages	(mult_stages)
	) i_mult_pipe (
		.clk_i		(clk_i),
		.arst_n_i	(arst_n_i),
		.start_i	(ex_valid && ex_is_mult && ex_write_en),
		.dest_i		(ex_dest),
		.operand_a_i	(ex_a),
		.operand_b_i	(ex_b),
		.done_o		(result.mult_valid),
		.done_dest_o	(result.mult_dest),
		.product_o	(result.mult_data)
	);

endmodule

// ==== vi_int_registers.sv ====
// Integer register file, two asynchronous read ports, one write port, x0 reads zero
`timescale 1ns/100ps

module vi_int_registers (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  vi_pkg::reg_addr_t rd_addr_a_i,
	input  vi_pkg::reg_addr_t rd_addr_b_i,
	input  logic              wr_en_i,
	input  vi_pkg::reg_addr_t wr_addr_i,
	input  vi_pkg::word_t     wr_data_i,
	output vi_pkg::word_t     rd_data_a_o,
	output vi_pkg::word_t     rd_data_b_o
);

	// x0 has no storage
	vi_pkg::word_t regs [1:31];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
	assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

endmodule

// ==== vi_issue_if.sv ====
// Issue bus carrying one decoded operation with its operands into execute
`timescale 1ns/100ps

interface vi_issue_if;

	logic              valid;
	vi_pkg::alu_op_e   alu_op;
	logic              is_mult;
	vi_pkg::reg_addr_t dest;
	logic              write_en;
	vi_pkg::word_t     operand_a;
	vi_pkg::word_t     operand_b;

	modport source (
		output valid,
		output alu_op,
		output is_mult,
		output dest,
		output write_en,
		output operand_a,
		output operand_b
	);

	modport sink (
		input valid,
		input alu_op,
		input is_mult,
		input dest,
		input write_en,
		input operand_a,
		input operand_b
	);

endinterface

// ==== vi_mult_pipe.sv ====
// Multiply pipeline, one product register per stage, a new multiply every cycle
`timescale 1ns/100ps

module vi_mult_pipe #(
	parameter int mult_stages = 5
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              start_i,
	input  vi_pkg::reg_addr_t dest_i,
	input  vi_pkg::word_t     operand_a_i,
	input  vi_pkg::word_t     operand_b_i,
	output logic              done_o,
	output vi_pkg::reg_addr_t done_dest_o,
	output vi_pkg::word_t     product_o
);

	logic [mult_stages-1:0] stage_valid;
	vi_pkg::reg_addr_t      stage_dest [mult_stages];
	vi_pkg::word_t          stage_prod [mult_stages];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[mult_stages-2:0], start_i};
	end

	// Low word of the product is the same for signed and unsigned operands
	always_ff @(posedge clk_i) begin
		stage_dest[0] <= dest_i;
		stage_prod[0] <= operand_a_i * operand_b_i;
		for (int k = 1; k < mult_stages; k++) begin
			stage_dest[k] <= stage_dest[k-1];
			stage_prod[k] <= stage_prod[k-1];
		end
	end

	assign done_o      = stage_valid[mult_stages-1];
	assign done_dest_o = stage_dest[mult_stages-1];
	assign product_o   = stage_prod[mult_stages-1];

	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		start_i |-> ##mult_stages done_o);

	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		done_o |-> $past(start_i, mult_stages));

endmodule

// ==== vi_pkg.sv ====
// Integer core shared widths, data types, opcodes and ALU operations
package vi_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// Major opcodes found in instr[6:0]
	typedef enum logic [6:0] {
		op_imm = 7'b0010011,
		op_reg = 7'b0110011,
		op_lui = 7'b0110111
	} opcode_e;

	// Operations of the single-cycle integer ALU
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_sll    = 4'd5,
		alu_srl    = 4'd6,
		alu_slt    = 4'd7,
		alu_pass_b = 4'd8
	} alu_op_e;

endpackage

// ==== vi_result_if.sv ====
// Result bus with the ALU and multiply slots, read by writeback and by decode bypass
`timescale 1ns/100ps

interface vi_result_if;

	logic              alu_valid;
	vi_pkg::reg_addr_t alu_dest;
	vi_pkg::word_t     alu_data;
	logic              mult_valid;
	vi_pkg::reg_addr_t mult_dest;
	vi_pkg::word_t     mult_data;

	modport source (
		output alu_valid, alu_dest, alu_data,
		output mult_valid, mult_dest, mult_data
	);

	modport sink (
		input alu_valid, alu_dest, alu_data,
		input mult_valid, mult_dest, mult_data
	);

	modport monitor (
		input alu_valid, alu_dest, alu_data,
		input mult_valid, mult_dest, mult_data
	);

endinterface

// ==== vi_writeback.sv ====
// Writeback register merging the ALU and multiply result slots into one register write
`timescale 1ns/100ps

module vi_writeback (
	input  logic              clk_i,
	input  logic              arst_n_i,
	vi_result_if.sink         result,
	output logic              wb_valid_o,
	output vi_pkg::reg_addr_t wb_dest_o,
	output vi_pkg::word_t     wb_data_o
);

	logic alu_take;
	logic mult_take;

	assign alu_take  = result.alu_valid && result.alu_dest != '0;
	assign mult_take = result.mult_valid && result.mult_dest != '0;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= alu_take || mult_take;
	end

	always_ff @(posedge clk_i) begin
		if (alu_take) begin
			wb_dest_o <= result.alu_dest;
			wb_data_o <= result.alu_data;
		end else if (mult_take) begin
			wb_dest_o <= result.mult_dest;
			wb_data_o <= result.mult_data;
		end
	end

	// Decode keeps the two slots apart
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(result.alu_valid && result.mult_valid));

	// A valid result slot never names x0
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(result.alu_valid || result.mult_valid) |-> (alu_take || mult_take));

endmodule
